// File: compile.f
logic/cpu_pkg.sv
logic/pipe_bus.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/trap_csr.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_core.sv
verif/cpu_tb.sv

// File: logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic prog_we,
	input logic [mem_addr_w-1:0] prog_addr,
	input word_t prog_data,
	input reg_idx_t dbg_addr,
	output word_t dbg_data,
	output word_t pc,
	output word_t cycles_consumed,
	output logic halted,
	output logic trap_valid,
	output word_t trap_epc,
	output cause_t trap_cause
);

	logic run_en;
	logic stall;
	logic branch_taken;
	logic trap_req;
	logic redirect;
	word_t branch_target;
	word_t trap_pc;
	word_t redirect_pc;

	if_id_bus i_if_id ();
	id_ex_bus i_id_ex ();
	ex_mem_bus i_ex_mem ();
	mem_wb_bus i_mem_wb ();

	assign run_en = !halted; // the whole pipeline freezes once halted.

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cycles_consumed <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			cycles_consumed <= cycles_consumed + 32'd1;
			if (i_mem_wb.valid && i_mem_wb.is_halt)
				halted <= 1'b1; // ebreak leaves MEM/WB on this edge.
		end
	end

	fetch_stage i_fetch (
		.clk(clk),
		.rst(rst),
		.run_en(run_en),
		.stall(stall),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.pc(pc),
		.if_id(i_if_id)
	);

	decode_stage i_decode (
		.clk(clk),
		.rst(rst),
		.run_en(run_en),
		.if_id(i_if_id),
		.id_ex(i_id_ex),
		.mem_wb(i_mem_wb),
		.branch_taken(branch_taken),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data),
		.stall(stall),
		.trap_req(trap_req),
		.trap_pc(trap_pc)
	);

	trap_csr i_trap_csr (
		.clk(clk),
		.rst(rst),
		.run_en(run_en),
		.trap_req(trap_req),
		.trap_pc(trap_pc),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.trap_valid(trap_valid),
		.trap_epc(trap_epc),
		.trap_cause(trap_cause)
	);

	execute_stage i_execute (
		.clk(clk),
		.rst(rst),
		.run_en(run_en),
		.stall(stall),
		.id_ex(i_id_ex),
		.ex_mem(i_ex_mem),
		.mem_wb(i_mem_wb),
		.branch_taken(branch_taken),
		.branch_target(branch_target)
	);

	memory_stage i_memory (
		.clk(clk),
		.rst(rst),
		.run_en(run_en),
		.ex_mem(i_ex_mem),
		.mem_wb(i_mem_wb)
	);

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [3:0] cause_t;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or
	} alu_op_e;

	typedef enum logic [1:0] {
		fwd_none,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	// major opcodes of the supported rv32i subset.
	localparam opcode_t opc_op = 7'b0110011;
	localparam opcode_t opc_op_imm = 7'b0010011;
	localparam opcode_t opc_load = 7'b0000011;
	localparam opcode_t opc_store = 7'b0100011;
	localparam opcode_t opc_branch = 7'b1100011;
	localparam opcode_t opc_system = 7'b1110011;

	localparam cause_t cause_illegal = 4'd2;
	localparam word_t trap_handler_addr = 32'h0000_0100;

	localparam int imem_words = 256;
	localparam int dmem_words = 256;
	localparam int mem_addr_w = 8; // word index into either memory.

	localparam word_t nop_inst = 32'h0000_0013; // addi x0, x0, 0.

endpackage

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run_en,
	if_id_bus.consumer if_id,
	id_ex_bus.producer id_ex,
	mem_wb_bus.consumer mem_wb,
	input logic branch_taken,
	input reg_idx_t dbg_addr,
	output word_t dbg_data,
	output logic stall,
	output logic trap_req,
	output word_t trap_pc
);

	word_t regs [32];
	opcode_t opcode;
	reg_idx_t rs1, rs2, rd;
	word_t imm_i, imm_s, imm_b, imm;
	word_t rs1_val, rs2_val;
	alu_op_e alu_op;
	logic use_imm, reg_write, mem_read, mem_write, is_branch, is_halt, illegal;
	logic uses_rs1, uses_rs2;
	logic wb_we, id_valid, load_use, issue, halt_pending;

	assign opcode = if_id.inst[6:0];
	assign rd = if_id.inst[11:7];
	assign rs1 = if_id.inst[19:15];
	assign rs2 = if_id.inst[24:20];
	assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
	assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
		if_id.inst[30:25], if_id.inst[11:8], 1'b0};

	always_comb begin
		alu_op = alu_add;
		imm = imm_i;
		use_imm = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		is_halt = 1'b0;
		illegal = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			opc_op_imm: begin
				illegal = (if_id.inst[14:12] != 3'b000); // only addi.
				use_imm = 1'b1;
				reg_write = 1'b1;
				uses_rs1 = 1'b1;
			end
			opc_op: begin
				reg_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				case ({if_id.inst[31:25], if_id.inst[14:12]})
					10'b0000000_000: alu_op = alu_add;
					10'b0100000_000: alu_op = alu_sub;
					10'b0000000_111: alu_op = alu_and;
					10'b0000000_110: alu_op = alu_or;
					default: illegal = 1'b1;
				endcase
			end
			opc_load: begin
				illegal = (if_id.inst[14:12] != 3'b010); // word loads only.
				use_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
				uses_rs1 = 1'b1;
			end
			opc_store: begin
				illegal = (if_id.inst[14:12] != 3'b010);
				imm = imm_s;
				use_imm = 1'b1;
				mem_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			opc_branch: begin
				illegal = (if_id.inst[14:12] != 3'b000); // beq only.
				imm = imm_b;
				is_branch = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			opc_system: begin
				is_halt = (if_id.inst == 32'h0010_0073); // ebreak.
				illegal = !is_halt;
			end
			default: illegal = 1'b1;
		endcase
	end

	assign wb_we = run_en && mem_wb.valid && mem_wb.reg_write && (mem_wb.rd_idx != 5'd0);

	// a write in WB this cycle is visible to the read in the same cycle.
	function automatic word_t read_reg(reg_idx_t idx);
		if (idx == 5'd0)
			return '0;
		if (wb_we && (mem_wb.rd_idx == idx))
			return mem_wb.wb_data;
		return regs[idx];
	endfunction

	always_comb begin
		rs1_val = read_reg(rs1);
		rs2_val = read_reg(rs2);
		dbg_data = read_reg(dbg_addr);
	end

	always_ff @(posedge clk) begin
		if (wb_we)
			regs[mem_wb.rd_idx] <= mem_wb.wb_data;
	end

	// nothing younger than an issued ebreak may enter the pipeline.
	assign id_valid = if_id.valid && !halt_pending;
	assign load_use = id_ex.valid && id_ex.mem_read && (id_ex.rd_idx != 5'd0) &&
		((uses_rs1 && (id_ex.rd_idx == rs1)) || (uses_rs2 && (id_ex.rd_idx == rs2)));
	assign stall = id_valid && load_use;
	assign trap_req = id_valid && illegal && !branch_taken;
	assign trap_pc = if_id.pc;
	assign issue = id_valid && !illegal && !stall && !branch_taken;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
			id_ex.reg_write <= 1'b0;
			id_ex.mem_read <= 1'b0;
			id_ex.mem_write <= 1'b0;
			id_ex.is_branch <= 1'b0;
			id_ex.is_halt <= 1'b0;
			halt_pending <= 1'b0;
		end else if (run_en) begin
			id_ex.valid <= issue;
			id_ex.reg_write <= issue && reg_write;
			id_ex.mem_read <= issue && mem_read;
			id_ex.mem_write <= issue && mem_write;
			id_ex.is_branch <= issue && is_branch;
			id_ex.is_halt <= issue && is_halt;
			if (issue && is_halt)
				halt_pending <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (run_en) begin
			id_ex.pc <= if_id.pc;
			id_ex.rs1_idx <= uses_rs1 ? rs1 : 5'd0; // unused fields never forward.
			id_ex.rs2_idx <= uses_rs2 ? rs2 : 5'd0;
			id_ex.rd_idx <= rd;
			id_ex.rs1_val <= rs1_val;
			id_ex.rs2_val <= rs2_val;
			id_ex.imm <= imm;
			id_ex.alu_op <= alu_op;
			id_ex.use_imm <= use_imm;
		end
	end

	// fetch must flush the trapping word so it cannot trap or stall again.
	a_single_squash: assert property (@(posedge clk) disable iff (rst || !run_en)
		trap_req |-> !stall ##1 !trap_req);

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run_en,
	input logic stall,
	id_ex_bus.consumer id_ex,
	ex_mem_bus.producer ex_mem,
	mem_wb_bus.consumer mem_wb,
	output logic branch_taken,
	output word_t branch_target
);

	fwd_sel_e fwd_a, fwd_b;
	word_t op_a, op_b, alu_b, alu_result;

	// the EX/MEM entry is younger than MEM/WB, so it wins.
	function automatic fwd_sel_e pick_fwd(reg_idx_t idx);
		if (idx == 5'd0)
			return fwd_none;
		if (ex_mem.valid && ex_mem.reg_write && (ex_mem.rd_idx == idx))
			return fwd_mem;
		if (mem_wb.valid && mem_wb.reg_write && (mem_wb.rd_idx == idx))
			return fwd_wb;
		return fwd_none;
	endfunction

	always_comb begin
		fwd_a = pick_fwd(id_ex.rs1_idx);
		fwd_b = pick_fwd(id_ex.rs2_idx);
		case (fwd_a)
			fwd_mem: op_a = ex_mem.alu_result;
			fwd_wb: op_a = mem_wb.wb_data;
			default: op_a = id_ex.rs1_val;
		endcase
		case (fwd_b)
			fwd_mem: op_b = ex_mem.alu_result;
			fwd_wb: op_b = mem_wb.wb_data;
			default: op_b = id_ex.rs2_val;
		endcase
	end

	assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

	always_comb begin
		case (id_ex.alu_op)
			alu_sub: alu_result = op_a - alu_b;
			alu_and: alu_result = op_a & alu_b;
			alu_or: alu_result = op_a | alu_b;
			default: alu_result = op_a + alu_b;
		endcase
	end

	assign branch_taken = id_ex.valid && id_ex.is_branch && (op_a == op_b);
	assign branch_target = id_ex.pc + id_ex.imm;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.reg_write <= 1'b0;
			ex_mem.mem_read <= 1'b0;
			ex_mem.mem_write <= 1'b0;
			ex_mem.is_halt <= 1'b0;
		end else if (run_en) begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.reg_write <= id_ex.valid && id_ex.reg_write;
			ex_mem.mem_read <= id_ex.valid && id_ex.mem_read;
			ex_mem.mem_write <= id_ex.valid && id_ex.mem_write;
			ex_mem.is_halt <= id_ex.valid && id_ex.is_halt;
		end
	end

	always_ff @(posedge clk) begin
		if (run_en) begin
			ex_mem.alu_result <= alu_result;
			ex_mem.store_data <= op_b;
			ex_mem.rd_idx <= id_ex.rd_idx;
		end
	end

	// the load-use stall in decode keeps a load result from forwarding out of MEM.
	a_no_load_fwd: assert property (@(posedge clk) disable iff (rst)
		(id_ex.valid && ((fwd_a == fwd_mem) || (fwd_b == fwd_mem))) |-> !ex_mem.mem_read);

	// a stalling load and a taken branch cannot share the EX slot.
	a_stall_vs_branch: assert property (@(posedge clk) disable iff (rst)
		!(stall && branch_taken));

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run_en,
	input logic stall,
	input logic branch_taken,
	input word_t branch_target,
	input logic redirect,
	input word_t redirect_pc,
	input logic prog_we,
	input logic [mem_addr_w-1:0] prog_addr,
	input word_t prog_data,
	output word_t pc,
	if_id_bus.producer if_id
);

	word_t imem [imem_words];
	word_t next_pc;
	logic flush;

	assign flush = redirect | branch_taken; // both squash the word fetched this cycle.

	always_comb begin
		if (redirect)
			next_pc = redirect_pc;
		else if (branch_taken)
			next_pc = branch_target;
		else if (stall)
			next_pc = pc;
		else
			next_pc = pc + 32'd4;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= '0;
			if_id.valid <= 1'b0;
		end else if (run_en) begin
			pc <= next_pc;
			if (flush)
				if_id.valid <= 1'b0;
			else if (!stall)
				if_id.valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (run_en) begin
			if (flush) begin
				if_id.inst <= nop_inst;
			end else if (!stall) begin
				if_id.pc <= pc;
				if_id.inst <= imem[pc[mem_addr_w+1:2]];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst && prog_we && run_en)
			imem[prog_addr] <= prog_data; // program load happens only under reset.
	end

	a_prog_only_in_reset: assert property (@(posedge clk) prog_we |-> rst);

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run_en,
	ex_mem_bus.consumer ex_mem,
	mem_wb_bus.producer mem_wb
);

	word_t dmem [dmem_words];
	logic [mem_addr_w-1:0] addr;
	word_t load_data;
	word_t wb_data;

	assign addr = ex_mem.alu_result[mem_addr_w+1:2]; // word addressed, low bits ignored.
	assign load_data = dmem[addr];
	assign wb_data = ex_mem.mem_read ? load_data : ex_mem.alu_result;

	always_ff @(posedge clk) begin
		if (run_en && ex_mem.valid && ex_mem.mem_write)
			dmem[addr] <= ex_mem.store_data;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			mem_wb.valid <= 1'b0;
			mem_wb.reg_write <= 1'b0;
			mem_wb.is_halt <= 1'b0;
		end else if (run_en) begin
			mem_wb.valid <= ex_mem.valid;
			mem_wb.reg_write <= ex_mem.valid && ex_mem.reg_write;
			mem_wb.is_halt <= ex_mem.valid && ex_mem.is_halt;
		end
	end

	always_ff @(posedge clk) begin
		if (run_en) begin
			mem_wb.wb_data <= wb_data;
			mem_wb.rd_idx <= ex_mem.rd_idx;
		end
	end

	// decode never sets both for one instruction.
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
		!(ex_mem.valid && ex_mem.mem_read && ex_mem.mem_write));

endmodule

// File: logic/pipe_bus.sv
`timescale 1ns/1ps

interface if_id_bus import cpu_pkg::*; ();
	logic valid;
	word_t pc;
	word_t inst;

	modport producer(output valid, pc, inst);
	modport consumer(input valid, pc, inst);
endinterface

interface id_ex_bus import cpu_pkg::*; ();
	logic valid;
	word_t pc;
	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	reg_idx_t rd_idx;
	word_t rs1_val;
	word_t rs2_val;
	word_t imm;
	alu_op_e alu_op;
	logic use_imm;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic is_branch;
	logic is_halt;

	modport producer(output valid, pc, rs1_idx, rs2_idx, rd_idx, rs1_val, rs2_val, imm,
		alu_op, use_imm, reg_write, mem_read, mem_write, is_branch, is_halt);
	modport consumer(input valid, pc, rs1_idx, rs2_idx, rd_idx, rs1_val, rs2_val, imm,
		alu_op, use_imm, reg_write, mem_read, mem_write, is_branch, is_halt);
endinterface

interface ex_mem_bus import cpu_pkg::*; ();
	logic valid;
	word_t alu_result;
	word_t store_data;
	reg_idx_t rd_idx;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic is_halt;

	modport producer(output valid, alu_result, store_data, rd_idx, reg_write, mem_read,
		mem_write, is_halt);
	modport consumer(input valid, alu_result, store_data, rd_idx, reg_write, mem_read,
		mem_write, is_halt);
endinterface

interface mem_wb_bus import cpu_pkg::*; ();
	logic valid;
	word_t wb_data;
	reg_idx_t rd_idx;
	logic reg_write;
	logic is_halt;

	modport producer(output valid, wb_data, rd_idx, reg_write, is_halt);
	modport consumer(input valid, wb_data, rd_idx, reg_write, is_halt);
endinterface

// File: logic/trap_csr.sv
`timescale 1ns/1ps

module trap_csr import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run_en,
	input logic trap_req,
	input word_t trap_pc,
	output logic redirect,
	output word_t redirect_pc,
	output logic trap_valid,
	output word_t trap_epc,
	output cause_t trap_cause
);

	logic take;

	assign take = run_en && trap_req;
	assign redirect = take; // fetch jumps on the same edge that records the trap.
	assign redirect_pc = trap_handler_addr;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			trap_valid <= 1'b0;
			trap_epc <= '0;
			trap_cause <= '0;
		end else if (take) begin
			trap_valid <= 1'b1; // sticky until reset.
			trap_epc <= trap_pc;
			trap_cause <= cause_illegal;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert --top-module cpu_tb -f compile.f -o cpu_tb_sim
status=0
./obj_dir/cpu_tb_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
fi
echo "simulation failed, exit status $status"
exit 1

// File: verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

	localparam int clk_period = 40;
	// program words, reset, run cycles, register reads and some slack for each test.
	localparam int chain_budget = 7 + 5 + 11 + 6 + 4;
	localparam int store_budget = 6 + 5 + 11 + 2 + 4;
	localparam int branch_budget = 9 + 5 + 13 + 4 + 4;
	localparam int trap_budget = 7 + 5 + 10 + 2 + 4;
	localparam int x0_budget = 3 + 5 + 7 + 2 + 4;
	localparam int total_budget = chain_budget + store_budget + branch_budget +
		trap_budget + x0_budget;

	logic clk;
	logic rst;
	logic prog_we;
	logic [mem_addr_w-1:0] prog_addr;
	word_t prog_data;
	reg_idx_t dbg_addr;
	word_t dbg_data;
	word_t pc;
	word_t cycles_consumed;
	logic halted;
	logic trap_valid;
	word_t trap_epc;
	cause_t trap_cause;

	word_t lfsr_state = 32'h2f35a8ba;
	word_t prog_q [$];
	string cur_test;

	cpu_core i_dut (
		.clk(clk),
		.rst(rst),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data),
		.pc(pc),
		.cycles_consumed(cycles_consumed),
		.halted(halted),
		.trap_valid(trap_valid),
		.trap_epc(trap_epc),
		.trap_cause(trap_cause)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic next_rand_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ 32'ha300_0000; // taps 32, 30, 26, 25.
		return b;
	endfunction

	function automatic logic [11:0] rand_imm12();
		logic [11:0] v;
		v = '0;
		for (int i = 0; i < 12; i++)
			v = {v[10:0], next_rand_bit()};
		return v;
	endfunction

	function automatic word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd, input opcode_t opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd, input opcode_t opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input opcode_t opc);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input opcode_t opc);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
	endfunction

	function automatic word_t ebreak_inst();
		return i_type(12'd1, 5'd0, 3'b000, 5'd0, opc_system);
	endfunction

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("** Error: %s %s expected %h actual %h", cur_test, what, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_cause(input string what, input cause_t exp, input cause_t act);
		if (act !== exp) begin
			$display("** Error: %s %s expected %0d actual %0d", cur_test, what, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "cause mismatch");
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error: %s %s expected %b actual %b", cur_test, what, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic start_reset();
		@(posedge clk);
		#2;
		rst = 1'b1;
	endtask

	task automatic finish_reset();
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	// writes the queued words from a word address on, one per clock.
	task automatic load_words(input int base);
		for (int i = 0; i < prog_q.size(); i++) begin
			prog_we = 1'b1;
			prog_addr = mem_addr_w'(base + i);
			prog_data = prog_q[i];
			@(posedge clk);
			#2;
		end
		prog_we = 1'b0;
		prog_q.delete();
	endtask

	task automatic wait_halt();
		do begin
			@(posedge clk);
			#2;
		end while (!halted);
	endtask

	task automatic check_reg(input reg_idx_t idx, input word_t exp);
		@(posedge clk);
		#2;
		dbg_addr = idx;
		#1;
		check_word($sformatf("x%0d", idx), exp, dbg_data);
	endtask

	task automatic dependent_chain();
		logic [11:0] imm_a, imm_b;
		word_t x1, x2, x3, x4, x5, x6;
		int n;
		cur_test = "dependent_chain";
		imm_a = rand_imm12();
		imm_b = rand_imm12();
		x1 = sext12(imm_a);
		x2 = x1 + sext12(imm_b);
		x3 = x2 + x1; // x2 comes from MEM and x1 from WB.
		x4 = x3 - x2;
		x5 = x4 & x3;
		x6 = x5 | x4;
		prog_q.push_back(i_type(imm_a, 5'd0, 3'b000, 5'd1, opc_op_imm));
		prog_q.push_back(i_type(imm_b, 5'd1, 3'b000, 5'd2, opc_op_imm));
		prog_q.push_back(r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd3, opc_op));
		prog_q.push_back(r_type(7'b0100000, 5'd2, 5'd3, 3'b000, 5'd4, opc_op));
		prog_q.push_back(r_type(7'b0000000, 5'd3, 5'd4, 3'b111, 5'd5, opc_op));
		prog_q.push_back(r_type(7'b0000000, 5'd4, 5'd5, 3'b110, 5'd6, opc_op));
		prog_q.push_back(ebreak_inst());
		n = prog_q.size();
		start_reset();
		load_words(0);
		finish_reset();
		wait_halt();
		check_word("cycles", 32'(n + 4), cycles_consumed);
		check_reg(5'd1, x1);
		check_reg(5'd2, x2);
		check_reg(5'd3, x3);
		check_reg(5'd4, x4);
		check_reg(5'd5, x5);
		check_reg(5'd6, x6);
	endtask

	task automatic store_load();
		logic [11:0] val;
		word_t v;
		int n;
		cur_test = "store_load";
		val = rand_imm12();
		v = sext12(val);
		prog_q.push_back(i_type(12'h040, 5'd0, 3'b000, 5'd7, opc_op_imm));
		prog_q.push_back(i_type(val, 5'd0, 3'b000, 5'd8, opc_op_imm));
		prog_q.push_back(s_type(12'h004, 5'd8, 5'd7, 3'b010, opc_store));
		prog_q.push_back(i_type(12'h004, 5'd7, 3'b010, 5'd9, opc_load));
		prog_q.push_back(r_type(7'b0000000, 5'd8, 5'd9, 3'b000, 5'd10, opc_op)); // needs x9 at once.
		prog_q.push_back(ebreak_inst());
		n = prog_q.size();
		start_reset();
		load_words(0);
		finish_reset();
		wait_halt();
		check_word("cycles", 32'(n + 5), cycles_consumed);
		check_reg(5'd9, v);
		check_reg(5'd10, v + v);
	endtask

	task automatic branches();
		logic [11:0] val;
		cur_test = "branches";
		val = rand_imm12() | 12'h001; // never zero, so the second beq falls through.
		prog_q.push_back(i_type(12'h000, 5'd0, 3'b000, 5'd11, opc_op_imm));
		prog_q.push_back(i_type(12'h000, 5'd0, 3'b000, 5'd12, opc_op_imm));
		prog_q.push_back(i_type(val, 5'd0, 3'b000, 5'd13, opc_op_imm));
		prog_q.push_back(b_type(13'd12, 5'd13, 5'd13, 3'b000, opc_branch));
		prog_q.push_back(i_type(12'h001, 5'd0, 3'b000, 5'd11, opc_op_imm));
		prog_q.push_back(i_type(12'h002, 5'd0, 3'b000, 5'd12, opc_op_imm));
		prog_q.push_back(b_type(13'd8, 5'd0, 5'd13, 3'b000, opc_branch));
		prog_q.push_back(i_type(12'h007, 5'd0, 3'b000, 5'd14, opc_op_imm));
		prog_q.push_back(ebreak_inst());
		start_reset();
		load_words(0);
		finish_reset();
		wait_halt();
		// seven instructions run and one branch is taken.
		check_word("cycles", 32'(7 + 4 + 2), cycles_consumed);
		check_reg(5'd11, 32'd0);
		check_reg(5'd12, 32'd0);
		check_reg(5'd13, sext12(val));
		check_reg(5'd14, 32'd7);
	endtask

	task automatic illegal_trap();
		cur_test = "illegal_trap";
		prog_q.push_back(i_type(12'h000, 5'd0, 3'b000, 5'd15, opc_op_imm));
		prog_q.push_back(i_type(12'h000, 5'd0, 3'b000, 5'd16, opc_op_imm));
		prog_q.push_back(32'h0000_000b); // custom opcode, unknown to this core.
		prog_q.push_back(i_type(12'h055, 5'd0, 3'b000, 5'd15, opc_op_imm));
		prog_q.push_back(ebreak_inst());
		start_reset();
		load_words(0);
		prog_q.push_back(i_type(12'h03c, 5'd0, 3'b000, 5'd16, opc_op_imm));
		prog_q.push_back(ebreak_inst());
		load_words(int'(trap_handler_addr >> 2));
		finish_reset();
		wait_halt();
		// five words pass through fetch in order, plus one squashed slot.
		check_word("cycles", 32'(5 + 4 + 1), cycles_consumed);
		check_flag("trap_valid", 1'b1, trap_valid);
		check_word("trap_epc", 32'h0000_0008, trap_epc);
		check_cause("trap_cause", cause_illegal, trap_cause);
		check_reg(5'd15, 32'd0);
		check_reg(5'd16, 32'h0000_003c);
	endtask

	task automatic reset_and_x0();
		logic [11:0] imm;
		int n;
		cur_test = "reset_and_x0";
		imm = rand_imm12() | 12'h001;
		prog_q.push_back(i_type(imm, 5'd0, 3'b000, 5'd0, opc_op_imm));
		prog_q.push_back(i_type(12'h00a, 5'd0, 3'b000, 5'd17, opc_op_imm)); // x0 must not forward.
		prog_q.push_back(ebreak_inst());
		n = prog_q.size();
		start_reset();
		load_words(0);
		finish_reset();
		#1;
		check_word("pc after reset", 32'd0, pc);
		check_word("cycles after reset", 32'd0, cycles_consumed);
		check_flag("halted after reset", 1'b0, halted);
		check_flag("trap_valid after reset", 1'b0, trap_valid);
		wait_halt();
		check_word("cycles", 32'(n + 4), cycles_consumed);
		check_reg(5'd0, 32'd0);
		check_reg(5'd17, 32'd10);
	endtask

	initial begin
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_addr = '0;
		dependent_chain();
		store_load();
		branches();
		illegal_trap();
		reset_and_x0();
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		#(total_budget * 2 * clk_period);
		$display("timeout: the tests did not finish within the cycle budget");
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule
